// ==== common/fmSynthPkg.sv ====
// shared widths, register layout, pipeline tag and sine table for the FM voice engine
`default_nettype none

package fmSynthPkg;

	// widths that carry a meaning
	typedef logic [3:0] channelIndex;
	typedef logic [19:0] phaseWord;
	typedef logic [5:0] tableIndex;
	typedef logic signed [7:0] waveByte;
	typedef logic signed [11:0] opSample;
	typedef logic signed [15:0] mixWord;
	typedef logic signed [11:0] pcmSample;

	// codes 8 to 15 fall back to sine
	typedef enum logic [3:0] {
		waveSine = 4'd0,
		waveHalf = 4'd1,
		waveFull = 4'd2,
		waveGated = 4'd3,
		waveGatedDouble = 4'd4,
		waveGatedDoubleFull = 4'd5,
		waveSquare = 4'd6,
		waveSaw = 4'd7
	} waveMode;

	// one operator control word, msb first
	typedef struct packed {
		waveMode mode;
		logic [2:0] shift;
		logic subHalf;
		logic subQuarter;
		logic subEighth;
		// only meaningful on operator A
		logic modulate;
		logic spare;
		phaseWord step;
	} operatorCtl;

	typedef struct packed {
		operatorCtl opA;
		operatorCtl opB;
	} channelCtl;

	typedef struct packed {
		phaseWord phaseA;
		phaseWord phaseB;
	} channelPhase;

	// rides along with each channel slot
	typedef struct packed {
		logic valid;
		channelIndex channel;
		logic lastChannel;
		logic stepping;
	} slotTag;

	typedef enum logic {
		restRotation,
		stepRotation
	} rotationMode;

	// one full period, peak 0x7F
	localparam waveByte sineTable [64] = '{
		8'sh00, 8'sh0C, 8'sh18, 8'sh24, 8'sh30, 8'sh3B, 8'sh46, 8'sh50,
		8'sh59, 8'sh62, 8'sh69, 8'sh70, 8'sh75, 8'sh79, 8'sh7C, 8'sh7E,
		8'sh7F, 8'sh7E, 8'sh7C, 8'sh79, 8'sh75, 8'sh70, 8'sh69, 8'sh62,
		8'sh59, 8'sh50, 8'sh46, 8'sh3B, 8'sh30, 8'sh24, 8'sh18, 8'sh0C,
		8'sh00, 8'shF4, 8'shE8, 8'shDC, 8'shD0, 8'shC5, 8'shBA, 8'shB0,
		8'shA7, 8'sh9E, 8'sh97, 8'sh90, 8'sh8B, 8'sh87, 8'sh84, 8'sh82,
		8'sh81, 8'sh82, 8'sh84, 8'sh87, 8'sh8B, 8'sh90, 8'sh97, 8'sh9E,
		8'shA7, 8'shB0, 8'shBA, 8'shC5, 8'shD0, 8'shDC, 8'shE8, 8'shF4
	};

	// dc offset left by the one-sided shapes
	function automatic waveByte biasFor(input waveMode mode);
		waveByte bias;
		case (mode)
			waveHalf, waveGated, waveGatedDoubleFull:
				bias = 8'sh28;
			waveFull:
				bias = 8'sh50;
			default:
				bias = 8'sh00;
		endcase
		return bias;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/channelSequencer.sv ====
// steps through the channels on each channel tick and marks stepping rotations
`timescale 1ns/100ps
`default_nettype none

module channelSequencer #(
	parameter int NumChannels = 16
) (
	input logic clock,
	input logic reset,
	input logic channelTick,
	input logic sampleTick,
	output fmSynthPkg::slotTag slot
);
	localparam fmSynthPkg::channelIndex LastChannel = fmSynthPkg::channelIndex'(NumChannels - 1);

	fmSynthPkg::channelIndex channel;
	fmSynthPkg::channelIndex nextChannel;
	fmSynthPkg::rotationMode mode;
	logic stepPending;
	logic rotationStart;

	// wrap after the last channel
	assign nextChannel = (channel == LastChannel) ? '0 : channel + 4'd1;
	// a tick that lands on channel 0 opens a rotation
	assign rotationStart = channelTick && (nextChannel == '0);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			// first tick then serves channel 0
			channel <= LastChannel;
			stepPending <= 1'b0;
			mode <= fmSynthPkg::restRotation;
			slot <= '0;
		end
		else
		begin
			slot.valid <= channelTick;
			slot.channel <= nextChannel;
			slot.lastChannel <= (nextChannel == LastChannel);
			// channel 0 decides from the pending flag directly
			slot.stepping <= rotationStart ? stepPending : (mode == fmSynthPkg::stepRotation);
			if (channelTick)
				channel <= nextChannel;
			// rotation start consumes the flag, a fresh sample tick refills it
			if (rotationStart)
				stepPending <= sampleTick;
			else if (sampleTick)
				stepPending <= 1'b1;
			case (mode)
				fmSynthPkg::restRotation:
					if (rotationStart && stepPending)
						mode <= fmSynthPkg::stepRotation;
				fmSynthPkg::stepRotation:
					if (rotationStart && !stepPending)
						mode <= fmSynthPkg::restRotation;
				default:
					mode <= fmSynthPkg::restRotation;
			endcase
		end
	end

	// one slot per tick, never stretched
	slotSingle: assert property (@(posedge clock) disable iff (reset)
		(slot.valid && !channelTick) |=> !slot.valid);

endmodule

`default_nettype wire

// ==== verilog/registerBank.sv ====
// operator control registers with bus write, registered bus read and per-slot control fetch
`timescale 1ns/100ps
`default_nettype none

module registerBank #(
	parameter int NumChannels = 16
) (
	input logic clock,
	input logic reset,
	input logic regWrite,
	input logic regRead,
	input logic [4:0] regAddr,
	input logic [31:0] regWriteData,
	output logic [31:0] regReadData,
	output logic readValid,
	input fmSynthPkg::slotTag slot,
	output fmSynthPkg::slotTag slotOut,
	output fmSynthPkg::channelCtl control
);
	fmSynthPkg::operatorCtl ctlA [NumChannels];
	fmSynthPkg::operatorCtl ctlB [NumChannels];

	// addr bit 0 picks the operator, bits 4 to 1 the channel
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < NumChannels; i++)
			begin
				ctlA[i] <= '0;
				ctlB[i] <= '0;
			end
		end
		else if (regWrite)
		begin
			if (regAddr[0])
				ctlB[regAddr[4:1]] <= fmSynthPkg::operatorCtl'(regWriteData);
			else
				ctlA[regAddr[4:1]] <= fmSynthPkg::operatorCtl'(regWriteData);
		end
	end

	// read data is zero outside the valid cycle
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			readValid <= 1'b0;
			regReadData <= '0;
			slotOut <= '0;
		end
		else
		begin
			readValid <= regRead;
			if (regRead)
				regReadData <= regAddr[0] ? ctlB[regAddr[4:1]] : ctlA[regAddr[4:1]];
			else
				regReadData <= '0;
			slotOut <= slot;
		end
	end

	// control pair of the slot's channel, lines up with slotOut
	always_ff @(posedge clock)
	begin
		control.opA <= ctlA[slot.channel];
		control.opB <= ctlB[slot.channel];
	end

	busExclusive: assert property (@(posedge clock) disable iff (reset) !(regWrite && regRead));

endmodule

`default_nettype wire

// ==== verilog/phaseAccumulator.sv ====
// phase memory for both operators of each channel, stepped once per stepping rotation
`timescale 1ns/100ps
`default_nettype none

module phaseAccumulator #(
	parameter int NumChannels = 16
) (
	input logic clock,
	input logic reset,
	input fmSynthPkg::slotTag slot,
	input fmSynthPkg::channelCtl control,
	output fmSynthPkg::channelPhase phase
);
	fmSynthPkg::channelPhase phaseMem [NumChannels];
	// tag of the slot whose old phases sit in phase
	fmSynthPkg::slotTag heldTag;

	// old phase out, operators always see the pre-step value
	always_ff @(posedge clock)
	begin
		phase <= phaseMem[slot.channel];
	end

	// write back one edge later, steps come from the bank's fetch of the same channel
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			heldTag <= '0;
			for (int i = 0; i < NumChannels; i++)
				phaseMem[i] <= '0;
		end
		else
		begin
			heldTag <= slot;
			if (heldTag.valid && heldTag.stepping)
			begin
				// 20-bit add wraps modulo 2^20
				phaseMem[heldTag.channel].phaseA <= phase.phaseA + control.opA.step;
				phaseMem[heldTag.channel].phaseB <= phase.phaseB + control.opB.step;
			end
		end
	end

endmodule

`default_nettype wire

// ==== operator/waveGenerator.sv ====
// sine lookup with optional modulation, wave mode shaping and bias removal, one cycle
`timescale 1ns/100ps
`default_nettype none

module waveGenerator (
	input logic clock,
	input logic reset,
	input fmSynthPkg::operatorCtl ctl,
	input fmSynthPkg::phaseWord phase,
	input fmSynthPkg::opSample modSample,
	input logic useMod,
	output fmSynthPkg::opSample shaped
);
	fmSynthPkg::tableIndex indexMain;
	fmSynthPkg::tableIndex indexDouble;
	fmSynthPkg::waveByte valueMain;
	fmSynthPkg::waveByte valueDouble;
	fmSynthPkg::waveByte wave;
	fmSynthPkg::waveByte bias;

	always_comb
	begin
		// top phase bits, double rate is one bit lower
		indexMain = phase[19:14];
		indexDouble = phase[18:13];
		// modulator offsets both reads
		if (useMod)
		begin
			indexMain = indexMain + modSample[9:4];
			indexDouble = indexDouble + modSample[9:4];
		end
		valueMain = fmSynthPkg::sineTable[indexMain];
		valueDouble = fmSynthPkg::sineTable[indexDouble];
		case (ctl.mode)
			fmSynthPkg::waveSine:
				wave = valueMain;
			fmSynthPkg::waveHalf:
				wave = valueMain[7] ? 8'sh00 : valueMain;
			// one's complement fold of the negative half
			fmSynthPkg::waveFull:
				wave = valueMain[7] ? ~valueMain : valueMain;
			// gates use the raw phase, not the modulated index
			fmSynthPkg::waveGated:
				wave = phase[18] ? 8'sh00 : valueMain;
			fmSynthPkg::waveGatedDouble:
				wave = phase[18] ? 8'sh00 : valueDouble;
			fmSynthPkg::waveGatedDoubleFull:
				wave = phase[18] ? 8'sh00 : (valueDouble[7] ? ~valueDouble : valueDouble);
			fmSynthPkg::waveSquare:
				wave = valueMain[7] ? 8'sh80 : 8'sh7F;
			// ramp built straight from the index bits
			fmSynthPkg::waveSaw:
				wave = {indexMain[5], ~indexMain[4:0], ~indexMain[5:4]};
			default:
				wave = valueMain;
		endcase
		bias = fmSynthPkg::biasFor(ctl.mode);
	end

	// byte moves to bits 10 to 3 of the 12-bit sample
	always_ff @(posedge clock)
	begin
		if (reset)
			shaped <= '0;
		else
			shaped <= {wave[7], wave, 3'b000} - {bias[7], bias, 3'b000};
	end

endmodule

`default_nettype wire

// ==== operator/levelScaler.sv ====
// fractional attenuation and arithmetic right shift of one operator sample, one cycle
`timescale 1ns/100ps
`default_nettype none

module levelScaler (
	input logic clock,
	input logic reset,
	input fmSynthPkg::operatorCtl ctl,
	input fmSynthPkg::opSample shaped,
	output fmSynthPkg::opSample sample
);
	fmSynthPkg::opSample attenuated;

	// each fraction taken from the untouched input
	always_comb
	begin
		attenuated = shaped;
		if (ctl.subEighth)
			attenuated = attenuated - (shaped >>> 3);
		if (ctl.subQuarter)
			attenuated = attenuated - (shaped >>> 2);
		if (ctl.subHalf)
			attenuated = attenuated - (shaped >>> 1);
	end

	// coarse level, 0 to 7 halvings
	always_ff @(posedge clock)
	begin
		if (reset)
			sample <= '0;
		else
			sample <= attenuated >>> ctl.shift;
	end

endmodule

`default_nettype wire

// ==== operator/fmOperator.sv ====
// one operator stage, wave then level, two cycles with slot context carried alongside
`timescale 1ns/100ps
`default_nettype none

module fmOperator #(
	parameter bit IsOperatorB = 1'b0
) (
	input logic clock,
	input logic reset,
	input fmSynthPkg::channelCtl ctl,
	input fmSynthPkg::channelPhase phase,
	input fmSynthPkg::opSample modSample,
	input logic useMod,
	input fmSynthPkg::slotTag tagIn,
	output fmSynthPkg::slotTag tagOut,
	output fmSynthPkg::channelCtl ctlOut,
	output fmSynthPkg::channelPhase phaseOut,
	output fmSynthPkg::opSample sample
);
	// context after the wave stage
	fmSynthPkg::slotTag tagWave;
	fmSynthPkg::channelCtl ctlWave;
	fmSynthPkg::channelPhase phaseWave;
	fmSynthPkg::opSample shaped;
	fmSynthPkg::operatorCtl opCtl;
	fmSynthPkg::operatorCtl opCtlWave;
	fmSynthPkg::phaseWord opPhase;

	// pick this operator's half of the channel
	assign opCtl = IsOperatorB ? ctl.opB : ctl.opA;
	assign opCtlWave = IsOperatorB ? ctlWave.opB : ctlWave.opA;
	assign opPhase = IsOperatorB ? phase.phaseB : phase.phaseA;

	waveGenerator waveStage (
		.clock(clock), .reset(reset), .ctl(opCtl), .phase(opPhase),
		.modSample(modSample), .useMod(useMod), .shaped(shaped)
	);

	// level uses the control word that travelled with the wave
	levelScaler levelStage (
		.clock(clock), .reset(reset), .ctl(opCtlWave), .shaped(shaped), .sample(sample)
	);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tagWave <= '0;
			tagOut <= '0;
		end
		else
		begin
			tagWave <= tagIn;
			tagOut <= tagWave;
		end
	end

	always_ff @(posedge clock)
	begin
		ctlWave <= ctl;
		ctlOut <= ctlWave;
		phaseWave <= phase;
		phaseOut <= phaseWave;
	end

endmodule

`default_nettype wire

// ==== verilog/channelMixer.sv ====
// sums channel outputs with overflow hold and emits a saturated sample per rotation
`timescale 1ns/100ps
`default_nettype none

module channelMixer (
	input logic clock,
	input logic reset,
	input fmSynthPkg::slotTag tag,
	input fmSynthPkg::operatorCtl ctlA,
	input fmSynthPkg::opSample sampleA,
	input fmSynthPkg::opSample sampleB,
	output fmSynthPkg::pcmSample pcm
);
	// operator B's sample arrives two cycles ahead of A's
	fmSynthPkg::opSample sampleBLate;
	fmSynthPkg::opSample sampleBAligned;
	fmSynthPkg::mixWord sum;
	fmSynthPkg::mixWord contribution;
	fmSynthPkg::mixWord nextSum;
	fmSynthPkg::pcmSample saturated;
	logic overflow;

	always_ff @(posedge clock)
	begin
		sampleBLate <= sampleB;
		sampleBAligned <= sampleBLate;
	end

	always_comb
	begin
		// carrier plus B, or A alone when B is the modulator
		contribution = fmSynthPkg::mixWord'(sampleA);
		if (!ctlA.modulate)
			contribution = contribution + fmSynthPkg::mixWord'(sampleBAligned);
		// near-zero step mutes the channel
		if (ctlA.step[19:8] == '0)
			contribution = '0;
		nextSum = sum + contribution;
		// same-sign inputs with a flipped result
		overflow = (sum[15] == contribution[15]) && (nextSum[15] != sum[15]);
		if (overflow)
			nextSum = sum;
		saturated = nextSum[12:1];
		if (nextSum[15:12] != 4'h0 && nextSum[15:12] != 4'hF)
			saturated = nextSum[15] ? 12'sh800 : 12'sh7FF;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			sum <= '0;
			pcm <= '0;
		end
		else if (tag.valid)
		begin
			// last channel closes the rotation
			if (tag.lastChannel)
			begin
				pcm <= saturated;
				sum <= '0;
			end
			else
				sum <= nextSum;
		end
	end

	pcmOnLast: assert property (@(posedge clock) disable iff (reset)
		!$stable(pcm) |-> $past(tag.valid && tag.lastChannel));

endmodule

`default_nettype wire

// ==== verilog/fmSynth.sv ====
// FM voice engine top level, ties sequencer, registers, phases, operators and mixer together
`timescale 1ns/100ps
`default_nettype none

module fmSynth #(
	parameter int NumChannels = 16
) (
	input logic clock,
	input logic reset,
	input logic channelTick,
	input logic sampleTick,
	input logic regWrite,
	input logic regRead,
	input logic [4:0] regAddr,
	input logic [31:0] regWriteData,
	output logic [31:0] regReadData,
	output logic readValid,
	output fmSynthPkg::pcmSample pcm
);
	// slot tags per stage
	fmSynthPkg::slotTag seqSlot;
	fmSynthPkg::slotTag bankSlot;
	fmSynthPkg::slotTag tagB;
	fmSynthPkg::slotTag tagA;
	// channel context per stage
	fmSynthPkg::channelCtl bankCtl;
	fmSynthPkg::channelCtl ctlB;
	fmSynthPkg::channelCtl ctlA;
	fmSynthPkg::channelPhase bankPhase;
	fmSynthPkg::channelPhase phaseB;
	fmSynthPkg::opSample sampleB;
	fmSynthPkg::opSample sampleA;

	channelSequencer #(.NumChannels(NumChannels)) sequencer (
		.clock(clock), .reset(reset), .channelTick(channelTick),
		.sampleTick(sampleTick), .slot(seqSlot)
	);

	registerBank #(.NumChannels(NumChannels)) bank (
		.clock(clock), .reset(reset), .regWrite(regWrite), .regRead(regRead),
		.regAddr(regAddr), .regWriteData(regWriteData), .regReadData(regReadData),
		.readValid(readValid), .slot(seqSlot), .slotOut(bankSlot), .control(bankCtl)
	);

	phaseAccumulator #(.NumChannels(NumChannels)) phaseMemory (
		.clock(clock), .reset(reset), .slot(seqSlot), .control(bankCtl), .phase(bankPhase)
	);

	// operator B runs first and never takes modulation
	fmOperator #(.IsOperatorB(1'b1)) operatorB (
		.clock(clock), .reset(reset), .ctl(bankCtl), .phase(bankPhase),
		.modSample('0), .useMod(1'b0), .tagIn(bankSlot), .tagOut(tagB),
		.ctlOut(ctlB), .phaseOut(phaseB), .sample(sampleB)
	);

	// operator A sees B's sample in the same slot
	fmOperator #(.IsOperatorB(1'b0)) operatorA (
		.clock(clock), .reset(reset), .ctl(ctlB), .phase(phaseB),
		.modSample(sampleB), .useMod(ctlB.opA.modulate), .tagIn(tagB), .tagOut(tagA),
		.ctlOut(ctlA), .phaseOut(), .sample(sampleA)
	);

	channelMixer mixer (
		.clock(clock), .reset(reset), .tag(tagA), .ctlA(ctlA.opA),
		.sampleA(sampleA), .sampleB(sampleB), .pcm(pcm)
	);

endmodule

`default_nettype wire

// ==== bench/fmSynthTb.sv ====
// directed testbench for the FM voice engine, checks bus access and pcm against a reference model
`timescale 1ns/100ps
`default_nettype none

module fmSynthTb;
	localparam int NumChannels = 16;
	// 2 muted, 6 sine, 32 wave mode and 6 loud rotations
	localparam int TotalRotations = 46;
	localparam int MaxSpacing = 4;
	localparam int TimeoutCycles = TotalRotations * NumChannels * MaxSpacing + 4000;

	logic clock;
	logic reset;
	logic channelTick;
	logic sampleTick;
	logic regWrite;
	logic regRead;
	logic [4:0] regAddr;
	logic [31:0] regWriteData;
	logic [31:0] regReadData;
	logic readValid;
	fmSynthPkg::pcmSample pcm;

	// model state
	fmSynthPkg::operatorCtl modelA [NumChannels];
	fmSynthPkg::operatorCtl modelB [NumChannels];
	fmSynthPkg::phaseWord phaseA [NumChannels];
	fmSynthPkg::phaseWord phaseB [NumChannels];
	bit pending;
	fmSynthPkg::pcmSample lastPcm;
	int errorCount = 0;
	int cycleCount = 0;

	fmSynth #(.NumChannels(NumChannels)) i_dut (
		.clock(clock), .reset(reset), .channelTick(channelTick), .sampleTick(sampleTick),
		.regWrite(regWrite), .regRead(regRead), .regAddr(regAddr),
		.regWriteData(regWriteData), .regReadData(regReadData), .readValid(readValid),
		.pcm(pcm)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// hang guard
	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("timeout: tests did not finish within %0d cycles", TimeoutCycles);
			$display("Result: FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
		assert (got === want)
		else
		begin
			errorCount++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
			$display("Result: FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// field order follows the control register layout
	function automatic logic [31:0] makeCtl(input logic [3:0] mode, input logic [2:0] shift,
		input logic [2:0] subs, input logic modulate, input logic [19:0] step);
		return {mode, shift, subs, modulate, 1'b0, step};
	endfunction

	function automatic logic [19:0] randomStep();
		return 20'($urandom_range(20'hFFFFF, 20'h00100));
	endfunction

	// one operator from the wave and level rules
	function automatic int operatorModel(input fmSynthPkg::operatorCtl c,
		input fmSynthPkg::phaseWord ph, input fmSynthPkg::opSample modIn, input bit useMod);
		fmSynthPkg::tableIndex first;
		fmSynthPkg::tableIndex second;
		fmSynthPkg::waveByte mainValue;
		fmSynthPkg::waveByte doubleValue;
		fmSynthPkg::waveByte w;
		logic [3:0] code;
		int bias;
		int level;
		int att;
		first = ph[19:14];
		second = ph[18:13];
		if (useMod)
		begin
			first = first + modIn[9:4];
			second = second + modIn[9:4];
		end
		mainValue = fmSynthPkg::sineTable[first];
		doubleValue = fmSynthPkg::sineTable[second];
		code = c.mode;
		bias = 0;
		case (code)
			4'd1:
			begin
				w = (mainValue < 0) ? 8'sh00 : mainValue;
				bias = 40;
			end
			4'd2:
			begin
				w = (mainValue < 0) ? ~mainValue : mainValue;
				bias = 80;
			end
			4'd3:
			begin
				w = ph[18] ? 8'sh00 : mainValue;
				bias = 40;
			end
			4'd4:
				w = ph[18] ? 8'sh00 : doubleValue;
			4'd5:
			begin
				w = ph[18] ? 8'sh00 : ((doubleValue < 0) ? ~doubleValue : doubleValue);
				bias = 40;
			end
			4'd6:
				w = (mainValue < 0) ? 8'sh80 : 8'sh7F;
			4'd7:
				w = {first[5], ~first[4:0], ~first[5:4]};
			default:
				w = mainValue;
		endcase
		// byte sits three bits up in the sample
		level = (int'(w) - bias) * 8;
		att = level;
		if (c.subEighth)
			att = att - (level >>> 3);
		if (c.subQuarter)
			att = att - (level >>> 2);
		if (c.subHalf)
			att = att - (level >>> 1);
		return att >>> c.shift;
	endfunction

	// expected pcm of the next rotation, steps phases when it is a stepping one
	task automatic predictRotation(output fmSynthPkg::pcmSample expected);
		int sum;
		int a;
		int b;
		int contrib;
		int next;
		bit stepping;
		stepping = pending;
		pending = 1'b0;
		sum = 0;
		for (int ch = 0; ch < NumChannels; ch++)
		begin
			b = operatorModel(modelB[ch], phaseB[ch], '0, 1'b0);
			a = operatorModel(modelA[ch], phaseA[ch], fmSynthPkg::opSample'(b),
				modelA[ch].modulate);
			contrib = modelA[ch].modulate ? a : a + b;
			if (modelA[ch].step[19:8] == 12'h000)
				contrib = 0;
			next = sum + contrib;
			// hold on 16-bit overflow
			if (next <= 32767 && next >= -32768)
				sum = next;
			if (stepping)
			begin
				phaseA[ch] = phaseA[ch] + modelA[ch].step;
				phaseB[ch] = phaseB[ch] + modelB[ch].step;
			end
		end
		if (sum > 4095)
			expected = 12'sh7FF;
		else if (sum < -4096)
			expected = 12'sh800;
		else
			expected = fmSynthPkg::pcmSample'(sum >>> 1);
	endtask

	task automatic writeRegister(input fmSynthPkg::channelIndex ch, input bit opB,
		input logic [31:0] data);
		@(negedge clock);
		regWrite = 1'b1;
		regAddr = {ch, opB};
		regWriteData = data;
		@(negedge clock);
		regWrite = 1'b0;
		if (opB)
			modelB[ch] = fmSynthPkg::operatorCtl'(data);
		else
			modelA[ch] = fmSynthPkg::operatorCtl'(data);
	endtask

	task automatic readRegister(input fmSynthPkg::channelIndex ch, input bit opB);
		logic [31:0] want;
		want = opB ? modelB[ch] : modelA[ch];
		@(negedge clock);
		regRead = 1'b1;
		regAddr = {ch, opB};
		checkValue("readValid", 32'(readValid), 32'd0);
		@(negedge clock);
		regRead = 1'b0;
		checkValue("readValid", 32'(readValid), 32'd1);
		checkValue("regReadData", regReadData, want);
		// valid lasts one cycle only
		@(negedge clock);
		checkValue("readValid", 32'(readValid), 32'd0);
		checkValue("regReadData", regReadData, 32'd0);
	endtask

	task automatic pulseSampleTick();
		@(negedge clock);
		sampleTick = 1'b1;
		@(negedge clock);
		sampleTick = 1'b0;
		pending = 1'b1;
	endtask

	// one tick per channel, random gaps up to maxSpacing
	task automatic runRotation(input int maxSpacing);
		fmSynthPkg::pcmSample expected;
		int spacing;
		predictRotation(expected);
		for (int ch = 0; ch < NumChannels; ch++)
		begin
			spacing = int'($urandom_range(maxSpacing, 1));
			repeat (spacing - 1)
			begin
				@(negedge clock);
				channelTick = 1'b0;
			end
			@(negedge clock);
			channelTick = 1'b1;
		end
		@(negedge clock);
		channelTick = 1'b0;
		// still the old value after five edges
		repeat (5) @(negedge clock);
		checkValue("pcm", 32'(pcm), 32'(lastPcm));
		@(negedge clock);
		checkValue("pcm", 32'(pcm), 32'(expected));
		lastPcm = expected;
	endtask

	task automatic testReset();
		repeat (5)
		begin
			@(negedge clock);
			checkValue("pcm", 32'(pcm), 32'd0);
			checkValue("readValid", 32'(readValid), 32'd0);
		end
	endtask

	task automatic testRegisterReadback();
		for (int ch = 0; ch < NumChannels; ch++)
		begin
			writeRegister(4'(ch), 1'b0, $urandom());
			writeRegister(4'(ch), 1'b1, $urandom());
		end
		for (int ch = 0; ch < NumChannels; ch++)
		begin
			readRegister(4'(ch), 1'b0);
			readRegister(4'(ch), 1'b1);
		end
	endtask

	// steps below 0x100 mute every channel
	task automatic testMutedChannels();
		for (int ch = 0; ch < NumChannels; ch++)
		begin
			writeRegister(4'(ch), 1'b0, $urandom() & 32'hFFF000FF);
			writeRegister(4'(ch), 1'b1, $urandom() & 32'hFFF000FF);
		end
		runRotation(MaxSpacing);
		checkValue("pcm", 32'(pcm), 32'd0);
		pulseSampleTick();
		runRotation(MaxSpacing);
		checkValue("pcm", 32'(pcm), 32'd0);
	endtask

	task automatic testSingleSine();
		fmSynthPkg::pcmSample previous;
		writeRegister(4'd0, 1'b0, makeCtl(4'd0, 3'd0, 3'd0, 1'b0, randomStep()));
		writeRegister(4'd0, 1'b1, makeCtl(4'd0, 3'd0, 3'd0, 1'b0, randomStep()));
		for (int ch = 1; ch < NumChannels; ch++)
		begin
			writeRegister(4'(ch), 1'b0, 32'd0);
			writeRegister(4'(ch), 1'b1, 32'd0);
		end
		for (int i = 0; i < 6; i++)
		begin
			previous = lastPcm;
			if (i % 2 == 0)
				pulseSampleTick();
			runRotation(MaxSpacing);
			// previous rotation left the phases as they were
			if (i % 2 == 0 && i > 0)
				checkValue("pcm", 32'(pcm), 32'(previous));
		end
	endtask

	task automatic testWaveModes();
		for (int mode = 0; mode < 8; mode++)
		begin
			for (int mod = 0; mod < 2; mod++)
			begin
				for (int ch = 0; ch < 4; ch++)
				begin
					writeRegister(4'(ch), 1'b0, makeCtl(4'(mode), 3'($urandom_range(7, 0)),
						3'($urandom_range(7, 0)), mod[0], randomStep()));
					writeRegister(4'(ch), 1'b1, makeCtl(4'($urandom_range(7, 0)),
						3'($urandom_range(7, 0)), 3'($urandom_range(7, 0)), 1'b0,
						randomStep()));
				end
				pulseSampleTick();
				runRotation(MaxSpacing);
				runRotation(MaxSpacing);
			end
		end
	endtask

	// gated and square waves at full level drive the sum to the rails
	task automatic testLoudMix();
		for (int ch = 0; ch < NumChannels; ch++)
		begin
			writeRegister(4'(ch), 1'b0, makeCtl(($urandom_range(1, 0) != 0) ? 4'd3 : 4'd6,
				3'd0, 3'd0, 1'b0, 20'($urandom_range(20'hFFFFF, 20'h10000))));
			writeRegister(4'(ch), 1'b1, makeCtl(($urandom_range(1, 0) != 0) ? 4'd3 : 4'd6,
				3'd0, 3'd0, 1'b0, 20'($urandom_range(20'hFFFFF, 20'h10000))));
		end
		for (int i = 0; i < 6; i++)
		begin
			pulseSampleTick();
			runRotation(1);
		end
	endtask

	initial
	begin
		void'($urandom(32'h9a7acc55));
		reset = 1'b1;
		channelTick = 1'b0;
		sampleTick = 1'b0;
		regWrite = 1'b0;
		regRead = 1'b0;
		regAddr = '0;
		regWriteData = '0;
		pending = 1'b0;
		lastPcm = '0;
		for (int ch = 0; ch < NumChannels; ch++)
		begin
			modelA[ch] = '0;
			modelB[ch] = '0;
			phaseA[ch] = '0;
			phaseB[ch] = '0;
		end
		repeat (10) @(negedge clock);
		reset = 1'b0;
		testReset();
		testRegisterReadback();
		testMutedChannels();
		testSingleSine();
		testWaveModes();
		testLoudMix();
		if (errorCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
common/fmSynthPkg.sv
verilog/channelSequencer.sv
verilog/registerBank.sv
verilog/phaseAccumulator.sv
operator/waveGenerator.sv
operator/levelScaler.sv
operator/fmOperator.sv
verilog/channelMixer.sv
verilog/fmSynth.sv
bench/fmSynthTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP := fmSynthTb
FILELIST := project.f
OBJ_DIR := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the pass line shows up in the output
run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
